// File: include/l1_settings.svh
`ifndef L1_SETTINGS_SVH
`define L1_SETTINGS_SVH

// ====================================================================
// cache geometry
// ====================================================================

// byte address and word width
`define L1_ADDR_WID     16
`define L1_DATA_WID     32

// direct mapped, one word per line
`define L1_OFFSET_WID   2
`define L1_INDEX_WID    4
`define L1_TAG_WID      10
`define L1_LINES        16

// level-2 request credits
`define L1_MEM_CREDITS  2
`define L1_CREDIT_WID   2

`endif

// File: hw/l1_cache_pkg.sv
`include "l1_settings.svh"

package l1_cache_pkg;

    typedef enum logic [1:0] {INVALID, SHARED, EXCLUSIVE, MODIFIED} mesi_e;
    typedef enum logic [1:0] {MEM_READ, MEM_READ_EXCL, MEM_UPGRADE, MEM_WRITEBACK} mem_op_e;
    typedef enum logic {SNOOP_READ, SNOOP_INVALIDATE} snoop_op_e;

    typedef enum logic [2:0] {
        PROC_IDLE,
        PROC_LOOKUP,
        PROC_WRITEBACK,
        PROC_FETCH,
        PROC_WAIT_FILL,
        PROC_UPGRADE,
        PROC_WAIT_ACK
    } proc_state_e;

    typedef logic [`L1_ADDR_WID-1:0]  addr_t;
    typedef logic [`L1_DATA_WID-1:0]  word_t;
    typedef logic [`L1_INDEX_WID-1:0] line_index_t;
    typedef logic [`L1_TAG_WID-1:0]   line_tag_t;

    // address fields
    function automatic line_index_t addr_index(addr_t addr);
        return addr[`L1_OFFSET_WID +: `L1_INDEX_WID];
    endfunction

    function automatic line_tag_t addr_tag(addr_t addr);
        return addr[`L1_ADDR_WID-1 -: `L1_TAG_WID];
    endfunction

    function automatic addr_t line_addr(line_tag_t tag, line_index_t index);
        return {tag, index, {`L1_OFFSET_WID{1'b0}}};
    endfunction

endpackage

// File: hw/l1_mem_req_if.sv
// level-2 request channel, transfer on valid and ready
interface l1_mem_req_if;

    logic                  valid;
    logic                  ready;
    l1_cache_pkg::mem_op_e op;
    l1_cache_pkg::addr_t   addr;
    l1_cache_pkg::word_t   data;

    // cpu-side controller
    modport ctrl (
        output valid,
        output op,
        output addr,
        output data,
        input  ready
    );

    // credit port
    modport port (
        input  valid,
        input  op,
        input  addr,
        input  data,
        output ready
    );

endinterface

// File: hw/l1_cache_store.sv
`include "l1_settings.svh"

module l1_cache_store (
    input  logic                      clk,
    input  logic                      reset,
    input  l1_cache_pkg::line_index_t proc_index,
    output l1_cache_pkg::line_tag_t   proc_tag,
    output l1_cache_pkg::mesi_e       proc_state,
    output l1_cache_pkg::word_t       proc_data,
    input  l1_cache_pkg::line_index_t snoop_index,
    output l1_cache_pkg::line_tag_t   snoop_tag,
    output l1_cache_pkg::mesi_e       snoop_state,
    output l1_cache_pkg::word_t       snoop_data,
    input  logic                      proc_write,
    input  l1_cache_pkg::line_tag_t   proc_write_tag,
    input  l1_cache_pkg::mesi_e       proc_write_state,
    input  l1_cache_pkg::word_t       proc_write_data,
    input  logic                      snoop_write,
    input  l1_cache_pkg::mesi_e       snoop_write_state
);
    import l1_cache_pkg::*;

    line_tag_t tag_mem   [`L1_LINES];
    mesi_e     state_mem [`L1_LINES];
    word_t     data_mem  [`L1_LINES];

    // ====================================================================
    // lookup ports
    // ====================================================================

    assign proc_tag    = tag_mem[proc_index];
    assign proc_state  = state_mem[proc_index];
    assign proc_data   = data_mem[proc_index];

    assign snoop_tag   = tag_mem[snoop_index];
    assign snoop_state = state_mem[snoop_index];
    assign snoop_data  = data_mem[snoop_index];

    // ====================================================================
    // write ports
    // ====================================================================

    // every line starts invalid
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `L1_LINES; i++) begin
                state_mem[i] <= INVALID;
            end
        end else begin
            if (snoop_write) begin
                state_mem[snoop_index] <= snoop_write_state;
            end
            if (proc_write) begin
                state_mem[proc_index] <= proc_write_state;
            end
        end
    end

    // cpu side owns tag and data
    always_ff @(posedge clk) begin
        if (proc_write) begin
            tag_mem[proc_index]  <= proc_write_tag;
            data_mem[proc_index] <= proc_write_data;
        end
    end

endmodule

// File: hw/l1_proc_ctrl.sv
module l1_proc_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cpu_req_valid,
    input  logic                      cpu_req_write,
    input  l1_cache_pkg::addr_t       cpu_addr,
    input  l1_cache_pkg::word_t       cpu_wdata,
    output logic                      cpu_ready,
    output logic                      cpu_resp_valid,
    output l1_cache_pkg::word_t       cpu_rdata,
    output l1_cache_pkg::line_index_t proc_index,
    input  l1_cache_pkg::line_tag_t   proc_tag,
    input  l1_cache_pkg::mesi_e       proc_state,
    input  l1_cache_pkg::word_t       proc_data,
    output logic                      proc_write,
    output l1_cache_pkg::line_tag_t   proc_write_tag,
    output l1_cache_pkg::mesi_e       proc_write_state,
    output l1_cache_pkg::word_t       proc_write_data,
    input  logic                      snoop_busy,
    input  logic                      mem_resp_valid,
    input  l1_cache_pkg::word_t       mem_resp_data,
    input  logic                      mem_resp_shared,
    l1_mem_req_if.ctrl                mem
);
    import l1_cache_pkg::*;

    proc_state_e state;
    logic        req_write;
    addr_t       req_addr;
    word_t       req_wdata;
    word_t       fill_data;
    logic        fill_shared;
    logic        resp_seen;
    logic        hit;
    logic        owned;
    logic        mem_xfer;
    logic        finish;

    assign cpu_ready  = (state == PROC_IDLE);
    assign proc_index = addr_index(req_addr);
    assign hit        = (proc_state != INVALID) && (proc_tag == addr_tag(req_addr));
    assign owned      = (proc_state == EXCLUSIVE) || (proc_state == MODIFIED);
    assign mem_xfer   = mem.valid && mem.ready;

    // level-2 answer held until the store is free of snoop writes
    assign finish = resp_seen && !snoop_busy &&
                    ((state == PROC_WAIT_FILL) || (state == PROC_WAIT_ACK));

    // ====================================================================
    // store write
    // ====================================================================

    always_comb begin
        proc_write       = finish ||
                           ((state == PROC_LOOKUP) && !snoop_busy && hit && req_write && owned);
        proc_write_tag   = addr_tag(req_addr);
        proc_write_state = MODIFIED;
        proc_write_data  = req_wdata;
        // read fill keeps the level-2 word
        if ((state == PROC_WAIT_FILL) && !req_write) begin
            proc_write_state = fill_shared ? SHARED : EXCLUSIVE;
            proc_write_data  = fill_data;
        end
    end

    // ====================================================================
    // level-2 request
    // ====================================================================

    always_comb begin
        mem.valid = 1'b0;
        mem.op    = req_write ? MEM_READ_EXCL : MEM_READ;
        mem.addr  = line_addr(addr_tag(req_addr), proc_index);
        mem.data  = proc_data;
        case (state)
            PROC_WRITEBACK: begin
                mem.valid = 1'b1;
                mem.op    = MEM_WRITEBACK;
                mem.addr  = line_addr(proc_tag, proc_index);
            end
            PROC_FETCH: begin
                mem.valid = 1'b1;
            end
            PROC_UPGRADE: begin
                mem.valid = 1'b1;
                mem.op    = MEM_UPGRADE;
            end
            default: begin
                mem.valid = 1'b0;
            end
        endcase
    end

    // ====================================================================
    // FSM
    // ====================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= PROC_IDLE;
            cpu_resp_valid <= 1'b0;
            resp_seen      <= 1'b0;
        end else begin
            cpu_resp_valid <= 1'b0;
            if (mem_resp_valid) begin
                resp_seen <= 1'b1;
            end
            case (state)
                PROC_IDLE: begin
                    if (cpu_req_valid) begin
                        state <= PROC_LOOKUP;
                    end
                end
                PROC_LOOKUP: begin
                    if (!snoop_busy) begin
                        if (hit && (!req_write || owned)) begin
                            cpu_resp_valid <= 1'b1;
                            state          <= PROC_IDLE;
                        end else if (hit) begin
                            state <= PROC_UPGRADE;
                        end else if (proc_state == MODIFIED) begin
                            state <= PROC_WRITEBACK;
                        end else begin
                            state <= PROC_FETCH;
                        end
                    end
                end
                PROC_WRITEBACK: begin
                    if (mem_xfer) begin
                        state <= PROC_FETCH;
                    end
                end
                PROC_FETCH: begin
                    if (mem_xfer) begin
                        state <= PROC_WAIT_FILL;
                    end
                end
                PROC_UPGRADE: begin
                    if (mem_xfer) begin
                        state <= PROC_WAIT_ACK;
                    end
                end
                PROC_WAIT_FILL, PROC_WAIT_ACK: begin
                    if (finish) begin
                        resp_seen      <= 1'b0;
                        cpu_resp_valid <= 1'b1;
                        state          <= PROC_IDLE;
                    end
                end
                default: begin
                    state <= PROC_IDLE;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_ready) begin
            req_write <= cpu_req_write;
            req_addr  <= cpu_addr;
            req_wdata <= cpu_wdata;
        end
        if (mem_resp_valid) begin
            fill_data   <= mem_resp_data;
            fill_shared <= mem_resp_shared;
        end
        if (state == PROC_LOOKUP) begin
            cpu_rdata <= req_write ? req_wdata : proc_data;
        end else if (finish) begin
            cpu_rdata <= proc_write_data;
        end
    end

endmodule

// File: hw/l1_snoop_ctrl.sv
module l1_snoop_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      snoop_valid,
    input  l1_cache_pkg::snoop_op_e   snoop_op,
    input  l1_cache_pkg::addr_t       snoop_addr,
    output l1_cache_pkg::line_index_t snoop_index,
    input  l1_cache_pkg::line_tag_t   snoop_tag,
    input  l1_cache_pkg::mesi_e       snoop_state,
    input  l1_cache_pkg::word_t       snoop_data,
    output logic                      snoop_write,
    output l1_cache_pkg::mesi_e       snoop_write_state,
    output logic                      snoop_busy,
    output logic                      snoop_done,
    output logic                      snoop_hit,
    output logic                      snoop_dirty,
    output l1_cache_pkg::word_t       snoop_resp_data
);
    import l1_cache_pkg::*;

    logic      pend;
    snoop_op_e pend_op;
    addr_t     pend_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= 1'b0;
        end else begin
            pend <= snoop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (snoop_valid) begin
            pend_op   <= snoop_op;
            pend_addr <= snoop_addr;
        end
    end

    // ====================================================================
    // lookup and response
    // ====================================================================

    assign snoop_index = addr_index(pend_addr);
    assign snoop_hit   = pend && (snoop_state != INVALID) &&
                         (snoop_tag == addr_tag(pend_addr));
    assign snoop_dirty = snoop_hit && (snoop_state == MODIFIED);

    // modified line goes out with the response
    assign snoop_resp_data = snoop_dirty ? snoop_data : '0;
    assign snoop_done      = pend;

    // downgrade in the done cycle, cpu side holds off
    assign snoop_busy        = pend;
    assign snoop_write       = snoop_hit;
    assign snoop_write_state = (pend_op == SNOOP_READ) ? SHARED : INVALID;

endmodule

// File: hw/l1_mem_req_port.sv
`include "l1_settings.svh"

module l1_mem_req_port (
    input  logic                  clk,
    input  logic                  reset,
    l1_mem_req_if.port            mem,
    input  logic                  mem_credit,
    output logic                  mem_req_valid,
    output l1_cache_pkg::mem_op_e mem_req_op,
    output l1_cache_pkg::addr_t   mem_req_addr,
    output l1_cache_pkg::word_t   mem_req_data
);
    import l1_cache_pkg::*;

    logic [`L1_CREDIT_WID-1:0] credits;
    logic                      xfer;

    // no request leaves without a credit
    assign mem.ready = (credits != '0);
    assign xfer      = mem.valid && mem.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits       <= `L1_CREDIT_WID'(`L1_MEM_CREDITS);
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= xfer;
            if (xfer && !mem_credit) begin
                credits <= credits - 1'b1;
            end else if (mem_credit && !xfer) begin
                credits <= credits + 1'b1;
            end
        end
    end

    // one-cycle request pulse toward level 2
    always_ff @(posedge clk) begin
        if (xfer) begin
            mem_req_op   <= mem.op;
            mem_req_addr <= mem.addr;
            // only write-backs carry data
            mem_req_data <= (mem.op == MEM_WRITEBACK) ? mem.data : '0;
        end
    end

endmodule

// File: hw/l1_dcache_top.sv
module l1_dcache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cpu_req_valid,
    input  logic                    cpu_req_write,
    input  l1_cache_pkg::addr_t     cpu_addr,
    input  l1_cache_pkg::word_t     cpu_wdata,
    output logic                    cpu_ready,
    output logic                    cpu_resp_valid,
    output l1_cache_pkg::word_t     cpu_rdata,
    output logic                    mem_req_valid,
    output l1_cache_pkg::mem_op_e   mem_req_op,
    output l1_cache_pkg::addr_t     mem_req_addr,
    output l1_cache_pkg::word_t     mem_req_data,
    input  logic                    mem_credit,
    input  logic                    mem_resp_valid,
    input  l1_cache_pkg::word_t     mem_resp_data,
    input  logic                    mem_resp_shared,
    input  logic                    snoop_valid,
    input  l1_cache_pkg::snoop_op_e snoop_op,
    input  l1_cache_pkg::addr_t     snoop_addr,
    output logic                    snoop_done,
    output logic                    snoop_hit,
    output logic                    snoop_dirty,
    output l1_cache_pkg::word_t     snoop_data
);
    import l1_cache_pkg::*;

    line_index_t proc_index;
    line_tag_t   proc_tag;
    mesi_e       proc_state;
    word_t       proc_data;
    logic        proc_write;
    line_tag_t   proc_write_tag;
    mesi_e       proc_write_state;
    word_t       proc_write_data;
    line_index_t snoop_index;
    line_tag_t   snoop_tag;
    mesi_e       snoop_state;
    word_t       store_snoop_data;
    logic        snoop_write;
    mesi_e       snoop_write_state;
    logic        snoop_busy;

    l1_mem_req_if mem_req ();

    l1_cache_store u_store (
        .clk, .reset,
        .proc_index, .proc_tag, .proc_state, .proc_data,
        .snoop_index, .snoop_tag, .snoop_state, .snoop_data (store_snoop_data),
        .proc_write, .proc_write_tag, .proc_write_state, .proc_write_data,
        .snoop_write, .snoop_write_state
    );

    l1_proc_ctrl u_proc_ctrl (
        .clk, .reset,
        .cpu_req_valid, .cpu_req_write, .cpu_addr, .cpu_wdata,
        .cpu_ready, .cpu_resp_valid, .cpu_rdata,
        .proc_index, .proc_tag, .proc_state, .proc_data,
        .proc_write, .proc_write_tag, .proc_write_state, .proc_write_data,
        .snoop_busy,
        .mem_resp_valid, .mem_resp_data, .mem_resp_shared,
        .mem (mem_req.ctrl)
    );

    l1_snoop_ctrl u_snoop_ctrl (
        .clk, .reset,
        .snoop_valid, .snoop_op, .snoop_addr,
        .snoop_index, .snoop_tag, .snoop_state, .snoop_data (store_snoop_data),
        .snoop_write, .snoop_write_state,
        .snoop_busy, .snoop_done, .snoop_hit, .snoop_dirty,
        .snoop_resp_data (snoop_data)
    );

    l1_mem_req_port u_mem_req_port (
        .clk, .reset,
        .mem (mem_req.port),
        .mem_credit,
        .mem_req_valid, .mem_req_op, .mem_req_addr, .mem_req_data
    );

endmodule

// File: verification/l1_dcache_chk.sv
`include "l1_settings.svh"

module l1_dcache_chk (
    input logic clk,
    input logic reset,
    input logic mem_req_valid,
    input logic mem_credit,
    input logic cpu_resp_valid,
    input logic snoop_valid,
    input logic snoop_done
);

    int assert_errors = 0;

    // requests seen on level 2 and not yet paid back
    int outstanding;

    always @(posedge clk) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(mem_req_valid) - int'(mem_credit);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> outstanding < `L1_MEM_CREDITS)
    else begin
        $error("level-2 request issued with no credit left");
        assert_errors++;
    end

    resp_pulse: assert property (@(posedge clk) disable iff (reset)
        cpu_resp_valid |=> !cpu_resp_valid)
    else begin
        $error("cpu_resp_valid longer than one cycle");
        assert_errors++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        snoop_done |=> !snoop_done)
    else begin
        $error("snoop_done longer than one cycle");
        assert_errors++;
    end

    done_after_snoop: assert property (@(posedge clk) disable iff (reset)
        snoop_valid |=> snoop_done)
    else begin
        $error("snoop_done missing one cycle after snoop_valid");
        assert_errors++;
    end

    done_cause: assert property (@(posedge clk) disable iff (reset)
        snoop_done |-> $past(snoop_valid))
    else begin
        $error("snoop_done without a snoop one cycle earlier");
        assert_errors++;
    end

endmodule

bind l1_dcache_top l1_dcache_chk u_chk (
    .clk            (clk),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_credit     (mem_credit),
    .cpu_resp_valid (cpu_resp_valid),
    .snoop_valid    (snoop_valid),
    .snoop_done     (snoop_done)
);

// File: verification/l1_dcache_tb.sv
`include "l1_settings.svh"

module l1_dcache_tb;
    import l1_cache_pkg::*;

    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 300;
    localparam int CLK_PERIOD      = 4;

    logic      clk;
    logic      reset;
    logic      cpu_req_valid;
    logic      cpu_req_write;
    addr_t     cpu_addr;
    word_t     cpu_wdata;
    logic      cpu_ready;
    logic      cpu_resp_valid;
    word_t     cpu_rdata;
    logic      mem_req_valid;
    mem_op_e   mem_req_op;
    addr_t     mem_req_addr;
    word_t     mem_req_data;
    logic      mem_credit;
    logic      mem_resp_valid;
    word_t     mem_resp_data;
    logic      mem_resp_shared;
    logic      snoop_valid;
    snoop_op_e snoop_op;
    addr_t     snoop_addr;
    logic      snoop_done;
    logic      snoop_hit;
    logic      snoop_dirty;
    word_t     snoop_data;

    // level-2 model
    word_t     l2_mem [addr_t];
    mem_op_e   req_ops [$];
    addr_t     req_addrs [$];
    word_t     req_datas [$];
    addr_t     resp_q [$];
    int        req_count;
    int        credits_owed;
    int        resp_timer;
    int        credit_timer;
    int        shared_mode;
    logic      hold_credits;
    int        access_cycles;

    l1_dcache_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================================================================
    // level-2 side
    // ====================================================================

    // unwritten words get a pattern built from the whole address
    function automatic word_t l2_word(addr_t addr);
        if (l2_mem.exists(addr)) begin
            return l2_mem[addr];
        end
        return {addr ^ 16'h5a5a, addr};
    endfunction

    function automatic addr_t make_addr(int tag, int index);
        return {tag[`L1_TAG_WID-1:0], index[`L1_INDEX_WID-1:0], {`L1_OFFSET_WID{1'b0}}};
    endfunction

    always @(posedge clk) begin
        mem_resp_valid <= 1'b0;
        mem_credit     <= 1'b0;
        if (mem_req_valid) begin
            req_ops.push_back(mem_req_op);
            req_addrs.push_back(mem_req_addr);
            req_datas.push_back(mem_req_data);
            req_count++;
            credits_owed++;
            if (mem_req_op == MEM_WRITEBACK) begin
                l2_mem[mem_req_addr] = mem_req_data;
            end else begin
                resp_q.push_back(mem_req_addr);
            end
        end
        // responses and credits each come 1 to 5 cycles later
        if (resp_timer > 0) begin
            resp_timer--;
            if (resp_timer == 0) begin
                mem_resp_valid  <= 1'b1;
                mem_resp_data   <= l2_word(resp_q.pop_front());
                mem_resp_shared <= (shared_mode == 2) ? 1'($urandom_range(1, 0))
                                                      : shared_mode[0];
            end
        end else if (resp_q.size() != 0) begin
            resp_timer = $urandom_range(5, 1);
        end
        if (credit_timer > 0) begin
            credit_timer--;
            if (credit_timer == 0) begin
                mem_credit <= 1'b1;
                credits_owed--;
            end
        end else if (credits_owed != 0 && !hold_credits) begin
            credit_timer = $urandom_range(5, 1);
        end
    end

    // ====================================================================
    // helpers
    // ====================================================================

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic cpu_access(input logic is_write, input addr_t addr, input word_t wdata,
                              output word_t rdata);
        do begin
            @(posedge clk);
        end while (!cpu_ready);
        cpu_req_valid <= 1'b1;
        cpu_req_write <= is_write;
        cpu_addr      <= addr;
        cpu_wdata     <= wdata;
        @(posedge clk);
        cpu_req_valid <= 1'b0;
        access_cycles = 0;
        do begin
            @(posedge clk);
            access_cycles++;
        end while (!cpu_resp_valid);
        rdata = cpu_rdata;
    endtask

    // done is due exactly one cycle after the request
    task automatic send_snoop(input snoop_op_e op, input addr_t addr,
                              output logic hit, output logic dirty, output word_t data);
        @(posedge clk);
        snoop_valid <= 1'b1;
        snoop_op    <= op;
        snoop_addr  <= addr;
        @(posedge clk);
        snoop_valid <= 1'b0;
        @(posedge clk);
        check_value(snoop_done, 1, "snoop_done one cycle after snoop_valid");
        hit   = snoop_hit;
        dirty = snoop_dirty;
        data  = snoop_data;
    endtask

    // ====================================================================
    // directed tests
    // ====================================================================

    task automatic read_miss_then_hit();
        addr_t a;
        word_t rd;
        int    base;
        a    = make_addr(3, 1);
        base = req_count;
        cpu_access(1'b0, a, '0, rd);
        check_value(req_count - base, 1, "read miss sends one request");
        check_value(req_ops[base], MEM_READ, "read miss op");
        check_value(req_addrs[base], a, "read miss address");
        check_value(rd, l2_word(a), "read miss data");
        cpu_access(1'b0, a, '0, rd);
        check_value(access_cycles, 2, "read hit latency");
        check_value(req_count - base, 1, "read hit sends no request");
        check_value(rd, l2_word(a), "read hit data");
    endtask

    task automatic write_hit_exclusive();
        addr_t a;
        word_t rd;
        int    base;
        a           = make_addr(5, 2);
        shared_mode = 0;
        base        = req_count;
        cpu_access(1'b0, a, '0, rd);
        check_value(req_count - base, 1, "exclusive fill request");
        cpu_access(1'b1, a, 32'hc0de_0002, rd);
        check_value(access_cycles, 2, "write hit latency");
        check_value(req_count - base, 1, "write hit on exclusive line sends nothing");
        cpu_access(1'b0, a, '0, rd);
        check_value(rd, 32'hc0de_0002, "read after write hit");
    endtask

    task automatic evict_modified();
        addr_t old_a;
        addr_t a;
        word_t exp;
        word_t rd;
        int    base;
        old_a = make_addr(5, 2);
        a     = make_addr(6, 2);
        exp   = l2_word(a);
        base  = req_count;
        cpu_access(1'b0, a, '0, rd);
        check_value(req_count - base, 2, "eviction sends write-back and read");
        check_value(req_ops[base], MEM_WRITEBACK, "victim op");
        check_value(req_addrs[base], old_a, "victim address");
        check_value(req_datas[base], 32'hc0de_0002, "victim data");
        check_value(req_ops[base + 1], MEM_READ, "refill op");
        check_value(req_addrs[base + 1], a, "refill address");
        check_value(rd, exp, "refill data");
        check_value(l2_word(old_a), 32'hc0de_0002, "level-2 copy of victim");
    endtask

    task automatic upgrade_shared();
        addr_t a;
        word_t rd;
        int    base;
        a           = make_addr(7, 3);
        shared_mode = 1;
        base        = req_count;
        cpu_access(1'b0, a, '0, rd);
        check_value(req_count - base, 1, "shared fill request");
        cpu_access(1'b1, a, 32'h5eed_0004, rd);
        check_value(req_count - base, 2, "write to shared line sends one request");
        check_value(req_ops[base + 1], MEM_UPGRADE, "upgrade op");
        check_value(req_addrs[base + 1], a, "upgrade address");
        cpu_access(1'b0, a, '0, rd);
        check_value(rd, 32'h5eed_0004, "read after upgrade");
        check_value(req_count - base, 2, "read after upgrade hits");
    endtask

    task automatic snoop_read_modified();
        addr_t a;
        word_t rd;
        word_t sd;
        logic  hit;
        logic  dirty;
        int    base;
        a           = make_addr(8, 4);
        shared_mode = 0;
        cpu_access(1'b0, a, '0, rd);
        cpu_access(1'b1, a, 32'hd1e7_0005, rd);
        send_snoop(SNOOP_READ, a, hit, dirty, sd);
        check_value(hit, 1, "snoop read hit");
        check_value(dirty, 1, "snoop read dirty");
        check_value(sd, 32'hd1e7_0005, "snoop read data");
        base = req_count;
        cpu_access(1'b1, a, 32'hd1e7_0055, rd);
        check_value(req_count - base, 1, "write after snoop read sends one request");
        check_value(req_ops[base], MEM_UPGRADE, "line became shared");
        check_value(req_addrs[base], a, "upgrade address after snoop");
        cpu_access(1'b0, a, '0, rd);
        check_value(rd, 32'hd1e7_0055, "read after snoop and upgrade");
    endtask

    task automatic snoop_inv_and_backpressure();
        addr_t a;
        word_t exp;
        word_t rd;
        word_t sd;
        logic  hit;
        logic  dirty;
        int    base;
        a = make_addr(8, 4);
        send_snoop(SNOOP_INVALIDATE, a, hit, dirty, sd);
        check_value(hit, 1, "snoop invalidate hit");
        check_value(dirty, 1, "snoop invalidate dirty");
        exp  = l2_word(a);
        base = req_count;
        cpu_access(1'b0, a, '0, rd);
        check_value(req_count - base, 1, "read after invalidate misses");
        check_value(req_ops[base], MEM_READ, "read after invalidate op");
        check_value(rd, exp, "read after invalidate data");

        // three dirty victims, then let every credit come home
        shared_mode = 2;
        for (int i = 0; i < 3; i++) begin
            cpu_access(1'b1, make_addr(9, 8 + i), 32'h1000_0000 + i, rd);
        end
        while (credits_owed != 0 || credit_timer != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        hold_credits <= 1'b1;
        base = req_count;
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    cpu_access(1'b1, make_addr(12, 8 + i), 32'h2000_0000 + i, rd);
                end
            end
            begin
                while (req_count - base < `L1_MEM_CREDITS) begin
                    @(negedge clk);
                end
                repeat (40) @(negedge clk);
                check_value(req_count - base, `L1_MEM_CREDITS, "requests held without credits");
                @(posedge clk);
                hold_credits <= 1'b0;
            end
        join
        check_value(req_count - base, 6, "all held writes reached level 2");
        for (int i = 0; i < 3; i++) begin
            check_value(req_ops[base + 2 * i], MEM_WRITEBACK, "held write-back op");
            check_value(req_addrs[base + 2 * i], make_addr(9, 8 + i), "held write-back address");
            check_value(req_datas[base + 2 * i], 32'h1000_0000 + i, "held write-back data");
            check_value(req_ops[base + 2 * i + 1], MEM_READ_EXCL, "held fill op");
            check_value(req_addrs[base + 2 * i + 1], make_addr(12, 8 + i), "held fill address");
        end
        for (int i = 0; i < 3; i++) begin
            cpu_access(1'b0, make_addr(12, 8 + i), '0, rd);
            check_value(rd, 32'h2000_0000 + i, "read back held write");
        end
    endtask

    // ====================================================================
    // main sequence and watchdog
    // ====================================================================

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        cpu_req_valid   = 1'b0;
        cpu_req_write   = 1'b0;
        cpu_addr        = '0;
        cpu_wdata       = '0;
        mem_credit      = 1'b0;
        mem_resp_valid  = 1'b0;
        mem_resp_data   = '0;
        mem_resp_shared = 1'b0;
        snoop_valid     = 1'b0;
        snoop_op        = SNOOP_READ;
        snoop_addr      = '0;
        req_count       = 0;
        credits_owed    = 0;
        resp_timer      = 0;
        credit_timer    = 0;
        shared_mode     = 2;
        hold_credits    = 1'b0;
        void'($urandom(41));
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value(cpu_ready, 1, "cpu_ready after reset");
        check_value(mem_req_valid, 0, "mem_req_valid after reset");
        check_value(cpu_resp_valid, 0, "cpu_resp_valid after reset");
        check_value(snoop_done, 0, "snoop_done after reset");
        read_miss_then_hit();
        write_hit_exclusive();
        evict_modified();
        upgrade_shared();
        snoop_read_modified();
        snoop_inv_and_backpressure();
        repeat (4) @(posedge clk);
        if (DUT.u_chk.assert_errors == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d assertion failures in the checker", DUT.u_chk.assert_errors);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end
    end

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not finish in the allowed time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: build.f
+incdir+include
hw/l1_cache_pkg.sv
hw/l1_mem_req_if.sv
hw/l1_cache_store.sv
hw/l1_proc_ctrl.sv
hw/l1_snoop_ctrl.sv
hw/l1_mem_req_port.sv
hw/l1_dcache_top.sv
verification/l1_dcache_chk.sv
verification/l1_dcache_tb.sv
